//--- mac_pkg.sv
// packed-lane mac definitions

package mac_pkg;

  //////////////////////////////////////////////////////////////////////
  // data words
  //////////////////////////////////////////////////////////////////////

  // one packed sample, tap weight or partial sum
  typedef logic [63:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // lane precision
  //////////////////////////////////////////////////////////////////////

  // code 2'b11 is not used, any stage seeing it with ce flags an error
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,  // eight 8-bit lanes
    PREC_INT16 = 2'd1,  // four 16-bit lanes
    PREC_INT32 = 2'd2   // two 32-bit lanes
  } prec_e;

  // lanes per 64-bit word at each precision
  localparam int LANE8_N  = 8;
  localparam int LANE16_N = 4;
  localparam int LANE32_N = 2;

  //////////////////////////////////////////////////////////////////////
  // flow control
  //////////////////////////////////////////////////////////////////////

  // credit counter width, up to 15 credits in flight
  localparam int CREDIT_W = 4;

endpackage

//--- lane_mult.sv
// packed-lane integer multiplier

`timescale 1ns/1ps

module lane_mult
  import mac_pkg::*;
(
  input  prec_e prec_i,  // lane width select
  input  word_t a_i,     // broadcast sample
  input  word_t b_i,     // tap weight
  output word_t p_o      // lane-wise products, low lane bits only
);

  word_t p8;   // eight 8x8 products
  word_t p16;  // four 16x16 products
  word_t p32;  // two 32x32 products

  //////////////////////////////////////////////////////////////////////
  // per-lane products
  //////////////////////////////////////////////////////////////////////

  // each product is sized to its lane, so the upper half of the
  // full product is dropped and results wrap modulo the lane width

  for (genvar i = 0; i < LANE8_N; i++) begin : g_lane8
    assign p8[i*8 +: 8] = a_i[i*8 +: 8] * b_i[i*8 +: 8];
  end

  for (genvar i = 0; i < LANE16_N; i++) begin : g_lane16
    assign p16[i*16 +: 16] = a_i[i*16 +: 16] * b_i[i*16 +: 16];
  end

  for (genvar i = 0; i < LANE32_N; i++) begin : g_lane32
    assign p32[i*32 +: 32] = a_i[i*32 +: 32] * b_i[i*32 +: 32];
  end

  //////////////////////////////////////////////////////////////////////
  // precision select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (prec_i)
      PREC_INT8:  p_o = p8;
      PREC_INT16: p_o = p16;
      PREC_INT32: p_o = p32;
      default:    p_o = '0;  // illegal code gives a zero product
    endcase
  end

endmodule

//--- smac.sv
// sub-mac stage of the transposed fir chain

`timescale 1ns/1ps

module smac
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  ce_i,      // accepted sample this cycle
  input  logic  clear_i,   // zero the partial sum, wins over ce_i
  input  prec_e prec_i,    // lane width
  input  word_t data_i,    // broadcast sample
  input  word_t weight_i,  // this tap's weight
  input  word_t chain_i,   // partial sum from the next stage
  output word_t res_o      // registered partial sum to the previous stage
);

  word_t prod;   // lane-wise weight * sample
  word_t sum8;   // chain + prod, carry cut every 8 bits
  word_t sum16;  // carry cut every 16 bits
  word_t sum32;  // carry cut every 32 bits
  word_t sum_d;  // next partial sum at the selected precision
  word_t acc_q;  // partial sum register

  //////////////////////////////////////////////////////////////////////
  // multiply
  //////////////////////////////////////////////////////////////////////

  lane_mult lane_mult_i (
    .prec_i (prec_i),
    .a_i    (data_i),
    .b_i    (weight_i),
    .p_o    (prod)
  );

  //////////////////////////////////////////////////////////////////////
  // lane-wise chain add
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < LANE8_N; i++) begin : g_add8
    assign sum8[i*8 +: 8] = chain_i[i*8 +: 8] + prod[i*8 +: 8];  // lane carry dropped
  end

  for (genvar i = 0; i < LANE16_N; i++) begin : g_add16
    assign sum16[i*16 +: 16] = chain_i[i*16 +: 16] + prod[i*16 +: 16];
  end

  for (genvar i = 0; i < LANE32_N; i++) begin : g_add32
    assign sum32[i*32 +: 32] = chain_i[i*32 +: 32] + prod[i*32 +: 32];
  end

  always_comb begin
    case (prec_i)
      PREC_INT8:  sum_d = sum8;
      PREC_INT16: sum_d = sum16;
      PREC_INT32: sum_d = sum32;
      default:    sum_d = chain_i;  // pass the chain through on a bad code
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // partial sum register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;     // history flush
    end else if (ce_i) begin
      acc_q <= sum_d;  // advance only on accepted samples
    end
  end

  assign res_o = acc_q;

  // precision has to be a legal code whenever a sample is taken in
  a_prec_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
    ce_i |-> prec_i inside {PREC_INT8, PREC_INT16, PREC_INT32})
    else $error("smac: illegal precision code with ce");

endmodule

//--- weight_bank.sv
// tap weight register bank

`timescale 1ns/1ps

module weight_bank
  import mac_pkg::*;
#(
  parameter int N_TAPS = 4,               // number of taps
  parameter int TAP_W  = $clog2(N_TAPS)   // tap index width
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             wload_i,               // write strobe
  input  logic [TAP_W-1:0] wsel_i,                // tap to write
  input  word_t            wdata_i,               // new weight
  output word_t            weights_o [N_TAPS]     // one weight per tap
);

  // one register per tap, visible the cycle after the write
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < N_TAPS; i++) begin
        weights_o[i] <= '0;
      end
    end else if (wload_i && (wsel_i < N_TAPS)) begin
      weights_o[wsel_i] <= wdata_i;  // out of range index is ignored
    end
  end

  // a write must address an existing tap
  a_wsel_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    wload_i |-> (wsel_i < N_TAPS))
    else $error("weight_bank: tap index out of range");

endmodule

//--- credit_ctrl.sv
// credit forwarder and output valid

`timescale 1ns/1ps

module credit_ctrl
  import mac_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic out_credit_i,  // downstream freed one slot
  input  logic in_valid_i,    // upstream sample accepted
  output logic in_credit_o,   // one credit granted upstream
  output logic out_valid_o    // stage 0 holds a fresh result
);

  logic [CREDIT_W-1:0] held_q;   // credits from downstream not yet forwarded
  logic [CREDIT_W-1:0] held_d;
  logic [CREDIT_W-1:0] outst_q;  // credits granted upstream, not yet used
  logic [CREDIT_W-1:0] outst_d;
  logic                valid_q;  // in_valid_i delayed one cycle

  //////////////////////////////////////////////////////////////////////
  // held credits
  //////////////////////////////////////////////////////////////////////

  assign in_credit_o = (held_q != '0);  // forward at most one per cycle

  always_comb begin
    case ({out_credit_i, in_credit_o})
      2'b10:   held_d = held_q + CREDIT_W'(1);  // new credit, none forwarded
      2'b01:   held_d = held_q - CREDIT_W'(1);  // forwarded one
      default: held_d = held_q;                 // none, or in and out together
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // outstanding credits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case ({in_credit_o, in_valid_i})
      2'b10:   outst_d = outst_q + CREDIT_W'(1);  // grant
      2'b01:   outst_d = outst_q - CREDIT_W'(1);  // sample consumed a credit
      default: outst_d = outst_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q  <= '0;
      outst_q <= '0;
      valid_q <= 1'b0;
    end else begin
      held_q  <= held_d;
      outst_q <= outst_d;
      valid_q <= in_valid_i;  // stage 0 register loads on the same edge
    end
  end

  assign out_valid_o = valid_q;

  // outstanding count may not wrap past its top value
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
    !((outst_q == '1) && in_credit_o && !in_valid_i))
    else $error("credit_ctrl: outstanding credit counter overflow");

  // every sample needs a credit, the one granted this cycle counts too
  a_sample_has_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
    in_valid_i |-> ((outst_q != '0) || in_credit_o))
    else $error("credit_ctrl: sample without outstanding credit");

endmodule

//--- mac_chain_top.sv
// packed-lane fir mac chain top level

`timescale 1ns/1ps

module mac_chain_top
  import mac_pkg::*;
#(
  parameter int N_TAPS = 4,              // filter length
  parameter int TAP_W  = $clog2(N_TAPS)  // weight select width
) (
  input  logic             clk,
  input  logic             rst_n_i,
  // sample side
  input  logic             in_valid_i,
  input  word_t            in_data_i,
  output logic             in_credit_o,
  // control
  input  prec_e            prec_i,       // hold stable while samples in flight
  input  logic             clear_i,
  // weight load
  input  logic             wload_i,
  input  logic [TAP_W-1:0] wsel_i,
  input  word_t            wdata_i,
  // result side
  input  logic             out_credit_i,
  output logic             out_valid_o,
  output word_t            out_data_o
);

  word_t weights   [N_TAPS];  // tap weights from the bank
  word_t stage_res [N_TAPS];  // registered partial sum of each stage

  //////////////////////////////////////////////////////////////////////
  // weights and flow control
  //////////////////////////////////////////////////////////////////////

  weight_bank #(
    .N_TAPS (N_TAPS),
    .TAP_W  (TAP_W)
  ) weight_bank_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wload_i   (wload_i),
    .wsel_i    (wsel_i),
    .wdata_i   (wdata_i),
    .weights_o (weights)
  );

  credit_ctrl credit_ctrl_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .out_credit_i (out_credit_i),
    .in_valid_i   (in_valid_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // transposed-form stage chain
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < N_TAPS; k++) begin : g_stage
    word_t chain_in;  // partial sum coming from stage k+1

    if (k == N_TAPS - 1) begin : g_last
      assign chain_in = '0;  // end of chain
    end else begin : g_mid
      assign chain_in = stage_res[k+1];
    end

    smac smac_i (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .ce_i     (in_valid_i),  // broadcast, one accepted sample
      .clear_i  (clear_i),
      .prec_i   (prec_i),
      .data_i   (in_data_i),
      .weight_i (weights[k]),
      .chain_i  (chain_in),
      .res_o    (stage_res[k])
    );
  end

  assign out_data_o = stage_res[0];  // stage 0 register is the output register

endmodule

//--- tb_mac_chain.sv
// mac chain testbench

`timescale 1ns/1ps

module tb_mac_chain;
  import mac_pkg::*;

  localparam int N_TAPS      = 4;
  localparam int TAP_W       = $clog2(N_TAPS);
  localparam int RST_CYC     = 10;
  localparam int N_ROWS      = 21;
  localparam int TIMEOUT_CYC = N_ROWS * 20 + RST_CYC;  // generous per-row budget

  logic clk, rst_n_i, in_valid_i, clear_i, wload_i, out_credit_i;
  logic in_credit_o, out_valid_o;
  logic [TAP_W-1:0] wsel_i;
  word_t in_data_i, wdata_i, out_data_o;
  prec_e prec_i;

  // stimulus / expected table
  prec_e t_prec [N_ROWS];
  logic  t_clr  [N_ROWS];  // clear row, no sample
  word_t t_data [N_ROWS];
  int    t_cred [N_ROWS];  // credits returned before the row
  int    t_gap  [N_ROWS];  // idle cycles with credits withheld
  word_t t_exp  [N_ROWS];
  int    n_rows = 0;

  word_t wts  [N_TAPS];    // tap weights loaded into the DUT
  word_t hist [N_TAPS];    // model history, hist[k] = sample k accepted ago
  int returns = 0, grants_rx = 0, used_cnt = 0, valid_cnt = 0, cyc = 0;
  logic valid_seen = 1'b0;

  mac_chain_top #(.N_TAPS(N_TAPS), .TAP_W(TAP_W)) mac_chain_top_i (
    .clk(clk), .rst_n_i(rst_n_i), .in_valid_i(in_valid_i), .in_data_i(in_data_i),
    .in_credit_o(in_credit_o), .prec_i(prec_i), .clear_i(clear_i), .wload_i(wload_i),
    .wsel_i(wsel_i), .wdata_i(wdata_i), .out_credit_i(out_credit_i),
    .out_valid_o(out_valid_o), .out_data_o(out_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic check_eq(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic add_row(input prec_e p, input logic clr, input word_t d, input int cr,
                         input int gap);
    t_prec[n_rows] = p;
    t_clr[n_rows]  = clr;
    t_data[n_rows] = d;
    t_cred[n_rows] = cr;
    t_gap[n_rows]  = gap;
    n_rows++;
  endtask

  // direct-form fir over accepted samples, wrapped per lane
  function automatic word_t fir_ref(input prec_e p);
    int    lw, nl;
    word_t mask, a, b, acc, res;
    lw = (p == PREC_INT8) ? 8 : (p == PREC_INT16) ? 16 : 32;
    nl = (p == PREC_INT8) ? LANE8_N : (p == PREC_INT16) ? LANE16_N : LANE32_N;
    mask = (64'd1 << lw) - 64'd1;
    res  = '0;
    for (int l = 0; l < nl; l++) begin
      acc = '0;
      for (int k = 0; k < N_TAPS; k++) begin
        a   = (hist[k] >> (l * lw)) & mask;
        b   = (wts[k] >> (l * lw)) & mask;
        acc = (acc + a * b) & mask;  // lane never carries out
      end
      res = res | (acc << (l * lw));
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // credit and valid monitor, hang guard
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cyc++;
    if (cyc > TIMEOUT_CYC) begin
      $display("timeout: the DUT stopped granting credits or the run hung");
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
    if (rst_n_i) begin
      if (in_credit_o) grants_rx++;                    // one credit to upstream
      check_eq(out_valid_o, valid_seen, "out_valid_o one cycle after sample");
      if (out_valid_o) begin
        valid_cnt++;  // results delivered so far
        check_eq(valid_cnt <= grants_rx, 1'b1, "out_valid_o without a granted credit");
      end
      valid_seen = in_valid_i;
    end
  end

  initial begin
    word_t last_out;
    void'($urandom(44510));
    {rst_n_i, in_valid_i, clear_i, wload_i, out_credit_i} = '0;
    {in_data_i, wdata_i, wsel_i} = '0;
    prec_i = PREC_INT8;
    last_out = '0;
    for (int k = 0; k < N_TAPS; k++) wts[k] = {$urandom, $urandom};

    // impulse in every int8 lane, then zeros walk the taps out
    add_row(PREC_INT8, 0, 64'h0101_0101_0101_0101, 2, 0);
    for (int i = 0; i < 4; i++) add_row(PREC_INT8, 0, '0, (i == 0) ? 0 : 1, 0);
    add_row(PREC_INT16, 1, '0, 0, 0);
    for (int i = 0; i < 4; i++) add_row(PREC_INT16, 0, {$urandom, $urandom}, 1, (i == 2) ? 40 : 0);
    add_row(PREC_INT16, 0, 64'hFFFF_FFFF_FFFF_FFFF, 1, 0);  // wrap checks
    add_row(PREC_INT16, 0, 64'h8000_7FFF_FFFF_8001, 1, 0);
    add_row(PREC_INT32, 1, '0, 0, 0);
    for (int i = 0; i < 3; i++) add_row(PREC_INT32, 0, {$urandom, $urandom}, 1, 0);
    add_row(PREC_INT32, 0, 64'hFFFF_FFFF_FFFF_FFFF, 1, 0);
    add_row(PREC_INT32, 0, 64'h8000_0001_FFFF_FFFE, 1, 0);
    add_row(PREC_INT8, 1, '0, 0, 0);
    for (int i = 0; i < 2; i++) add_row(PREC_INT8, 0, {$urandom, $urandom}, 1, 0);

    // expected outputs from the model
    for (int k = 0; k < N_TAPS; k++) hist[k] = '0;
    for (int r = 0; r < N_ROWS; r++) begin
      if (t_clr[r]) begin
        for (int k = 0; k < N_TAPS; k++) hist[k] = '0;
        t_exp[r] = '0;
      end else begin
        for (int k = N_TAPS - 1; k > 0; k--) hist[k] = hist[k-1];
        hist[0]  = t_data[r];
        t_exp[r] = fir_ref(t_prec[r]);
      end
    end

    repeat (RST_CYC) @(posedge clk);
    #1 rst_n_i = 1'b1;
    repeat (5) begin
      step();
      check_eq(in_credit_o, 1'b0, "in_credit_o before any credit");
    end
    for (int k = 0; k < N_TAPS; k++) begin
      {wload_i, wsel_i, wdata_i} = {1'b1, TAP_W'(k), wts[k]};
      step();
    end
    wload_i = 1'b0;

    //////////////////////////////////////////////////////////////////////
    // table loop
    //////////////////////////////////////////////////////////////////////

    for (int r = 0; r < N_ROWS; r++) begin
      prec_i = t_prec[r];  // only changes on clear rows
      repeat (t_gap[r]) begin
        step();
        check_eq(out_data_o, last_out, "output held while credits withheld");
      end
      if (t_clr[r]) begin
        clear_i = 1'b1;
        step();
        clear_i = 1'b0;
        check_eq(out_data_o, t_exp[r], $sformatf("row %0d after clear", r));
      end else begin
        repeat (t_cred[r]) begin
          out_credit_i = 1'b1;
          step();
          out_credit_i = 1'b0;
          returns++;
          step();
        end
        while (grants_rx <= used_cnt) step();  // wait for a granted credit
        in_valid_i = 1'b1;
        in_data_i  = t_data[r];
        used_cnt++;
        step();
        in_valid_i = 1'b0;
        check_eq(out_valid_o, 1'b1, $sformatf("row %0d out_valid_o", r));
        check_eq(out_data_o, t_exp[r], $sformatf("row %0d out_data_o", r));
      end
      last_out = t_exp[r];
    end

    repeat (4) step();
    check_eq(grants_rx, returns, "in_credit_o pulses vs out_credit_i pulses");
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- files.f
mac_pkg.sv
lane_mult.sv
smac.sv
weight_bank.sv
credit_ctrl.sv
mac_chain_top.sv
tb_mac_chain.sv

//--- Bender.yml
package:
  name: mac_chain

sources:
  - mac_pkg.sv
  - lane_mult.sv
  - smac.sv
  - weight_bank.sv
  - credit_ctrl.sv
  - mac_chain_top.sv
  - target: simulation
    files:
      - tb_mac_chain.sv
